// File: verilog.f
common/main_bus_pkg.sv
common/cabinet_pkg.sv
hdl/main_decode.sv
hdl/main_ram.sv
security/security_shift.sv
hdl/cabinet_io.sv
psg_ports/psg_ports.sv
hdl/main_board.sv
sim/main_board_assertions.sv
sim/main_board_tb.sv

// File: Bender.yml
package:
  name: main_board

sources:
  # Shared packages
  - common/main_bus_pkg.sv
  - common/cabinet_pkg.sv

  # Board RTL, leaf blocks before the top level
  - hdl/main_decode.sv
  - hdl/main_ram.sv
  - security/security_shift.sv
  - hdl/cabinet_io.sv
  - psg_ports/psg_ports.sv
  - hdl/main_board.sv

  # Testbench and bound checks
  - target: simulation
    files:
      - sim/main_board_assertions.sv
      - sim/main_board_tb.sv

// File: sim/main_board_tb.sv
// Main board testbench
`timescale 1ns/10ps

module main_board_tb
    import main_bus_pkg::*;
    import cabinet_pkg::*;
();

    localparam int ram_aw = 11;
    localparam int n_rom  = 64;
    localparam int n_ram  = 48;
    localparam int n_hole = 8;          // Per unmapped region
    localparam int n_sec  = 4;          // Byte pairs through the protection chip
    localparam int n_cab  = 48;
    localparam int n_psg  = 32;
    // Cycles issued including reset and idle ones
    localparam int n_cycles = 8 + n_rom + 2 * n_ram + 3 * n_hole + 18 * n_sec + n_cab
                            + 3 * n_psg + 56 + 10;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    bus_req_t    cpu_req;
    bus_rsp_t    cpu_rsp;
    logic        rom_cs;
    logic [14:0] rom_addr;
    logic [7:0]  rom_data;
    joy_t        joy1, joy2;
    panel_t      panel;
    dip_t        dip;
    logic        flip_n;

    ////////////////////////////////////////////////////////////
    // Shadow state of the board

    logic [7:0]  ram_sh [0:2**ram_aw-1];
    logic [7:0]  sec_cur = 8'd0, sec_prev = 8'd0;
    logic [2:0]  sec_shamt = 3'd0;
    logic [3:0]  psg_addr = 4'd0;
    logic [7:0]  psg_regs [0:15];
    logic [7:0]  exp_q [$];             // Expected read data in issue order
    logic [15:0] wr_addrs [$];          // RAM addresses written in the fill loop
    logic        rd_sent = 1'b0;        // Read strobe seen at the last rising edge

    // Count raised by the bound protocol checks
    int unsigned sva_fails;

    always #4 clk = ~clk;               // 8 ns period

    main_board #(.ram_aw(ram_aw)) main_board_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .joy1     (joy1),
        .joy2     (joy2),
        .panel    (panel),
        .dip      (dip),
        .flip_n   (flip_n)
    );

    bind main_decode main_board_assertions main_board_assertions_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .rom_cs  (rom_cs)
    );

    assign sva_fails = main_board_inst.main_decode_inst.main_board_assertions_inst.fail_count;

    // Program ROM stand-in with one clk latency
    always @(posedge clk) begin
        if (rom_cs) begin
            rom_data <= rom_addr[7:0] + 8'h5a;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address helpers

    // Board address bit i comes from CPU pin src_bit(i)
    function automatic int src_bit(input int i);
        case (i)
            3:       return 4;
            4:       return 5;
            5:       return 9;
            6:       return 3;
            7:       return 6;
            8:       return 7;
            9:       return 8;
            default: return i;
        endcase
    endfunction

    function automatic logic [15:0] unscramble(input logic [15:0] s);
        logic [15:0] a;
        for (int i = 0; i < 16; i++) begin
            a[i] = s[src_bit(i)] ^ (i < 6);     // Low six lines inverted
        end
        return a;
    endfunction

    function automatic logic [15:0] scramble(input logic [15:0] a);
        logic [15:0] s;
        for (int i = 0; i < 16; i++) begin
            s[src_bit(i)] = a[i] ^ (i < 6);
        end
        return s;
    endfunction

    // I/O pins for a given port with random upper bits
    function automatic logic [15:0] port_addr(input logic [1:0] port);
        logic [15:0] a;
        a      = $urandom;
        a[1:0] = port;
        return scramble(a);
    endfunction

    function automatic logic [15:0] sec_addr(input logic a0);
        logic [15:0] a;
        a        = $urandom;
        a[15:13] = 3'b111;              // Protection window
        a[0]     = a0;
        return scramble(a);
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [7:0] expected_read(input cycle_kind_e kind, input logic [15:0] s);
        logic [15:0] a;
        logic [15:0] word;
        logic [7:0]  port_b;
        a      = unscramble(s);
        word   = {sec_cur, sec_prev} << sec_shamt;
        port_b = {dip.sw2[psg_regs[14][3:1]], 3'b000, dip.sw1};
        if (kind == io_rd) begin
            case (a[1:0])
                2'd0:    return (psg_addr == 4'd15) ? port_b : psg_regs[psg_addr];
                2'd1:    return {panel.coin, panel.service, 2'b11, panel.start, 2'b11};
                2'd2:    return {3'b111, joy2.punch, joy2.down, joy2.up, joy2.right, joy2.left};
                default: return {3'b111, joy1.punch, joy1.down, joy1.up, joy1.right, joy1.left};
            endcase
        end
        if (!a[15]) begin
            return a[7:0] + 8'h5a;      // ROM stand-in contents
        end
        case (a[14:13])
            2'b00:   return a[ram_aw] ? 8'hff : ram_sh[a[ram_aw-1:0]];
            2'b11:   return word[15:8];
            default: return 8'hff;      // Video and background
        endcase
    endfunction

    function automatic void apply_write(input cycle_kind_e kind, input logic [15:0] s,
                                        input logic [7:0] w);
        logic [15:0] a;
        a = unscramble(s);
        if (kind == io_wr) begin
            if (a[0]) begin
                psg_addr = w[3:0];      // Register select
            end else begin
                psg_regs[psg_addr] = w;
            end
        end else if (a[15:13] == 3'b100 && !a[ram_aw]) begin
            ram_sh[a[ram_aw-1:0]] = w;
        end else if (a[15:13] == 3'b111) begin
            if (a[0]) begin
                sec_prev = sec_cur;
                sec_cur  = w;
            end else begin
                sec_shamt = w[2:0];
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Checker and CPU cycles

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic randomize_inputs();
        logic [31:0] r1, r2;
        r1    = $urandom;
        r2    = $urandom;
        joy1  = r1[4:0];
        joy2  = r1[9:5];
        panel = r1[13:10];
        dip   = r2[11:0];
    endtask

    task automatic bus_cycle(input cycle_kind_e kind, input logic [15:0] s, input logic [7:0] w);
        @(negedge clk);
        randomize_inputs();
        cpu_req = '{valid: 1'b1, kind: kind, addr: s, wdata: w};
        if (kind == mem_rd || kind == io_rd) begin
            exp_q.push_back(expected_read(kind, s));
        end else begin
            apply_write(kind, s, w);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        randomize_inputs();
        cpu_req.valid = 1'b0;
    endtask

    // Request side seen by the DUT at the rising edge
    always @(posedge clk) begin
        rd_sent <= cpu_req.valid && (cpu_req.kind == mem_rd || cpu_req.kind == io_rd);
        if (cpu_req.valid && cpu_req.kind == mem_rd && !cpu_req.addr[15]) begin
            check_value("rom_cs", rom_cs, 1'b1);
            check_value("rom_addr", rom_addr, unscramble(cpu_req.addr) & 16'h7fff);
        end
    end

    // Response one clk after each read and never otherwise
    always @(negedge clk) begin
        check_value("cpu_rsp.valid", cpu_rsp.valid, rd_sent);
        if (rd_sent) begin
            check_value("cpu_rsp.rdata", cpu_rsp.rdata, exp_q.pop_front());
        end
    end

    always @(negedge clk) begin
        if (sva_fails != 0) begin
            $display("Bus protocol assertion failed before %0t", $time);
            $display("** FAIL **");
            $fatal(1, "Protocol assertion failed");
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [15:0] s;
        logic [7:0]  w;
        void'($urandom(32'hbd62));
        cpu_req  = '0;
        rom_data = 8'h00;
        for (int i = 0; i < 16; i++) begin
            psg_regs[i] = 8'h00;
        end
        randomize_inputs();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // ROM reads
        for (int i = 0; i < n_rom; i++) begin
            s     = $urandom;
            s[15] = 1'b0;               // A15 low
            bus_cycle(mem_rd, s, 8'h00);
        end
        idle_cycle();

        // RAM fill then back to back reads through the A12 mirror
        for (int i = 0; i < n_ram; i++) begin
            s         = $urandom;
            s[15:13]  = 3'b100;
            s[ram_aw] = 1'b0;
            wr_addrs.push_back(s);
            bus_cycle(mem_wr, s, 8'($urandom));
        end
        foreach (wr_addrs[i]) begin
            bus_cycle(mem_rd, wr_addrs[i] ^ 16'h1000, 8'h00);
        end
        for (int i = 0; i < n_hole; i++) begin
            s         = $urandom;
            s[15:13]  = 3'b100;
            s[ram_aw] = 1'b1;           // Hole above RAM
            bus_cycle(mem_rd, s, 8'h00);
            s[15:13]  = 3'b101;
            bus_cycle(mem_rd, s, 8'h00);
            s[15:13]  = 3'b110;
            bus_cycle(mem_rd, s, 8'h00);
        end
        idle_cycle();

        // Protection chip over every shift amount
        for (int r = 0; r < n_sec; r++) begin
            bus_cycle(mem_wr, sec_addr(1'b1), 8'($urandom));
            bus_cycle(mem_wr, sec_addr(1'b1), 8'($urandom));
            for (int sh = 0; sh < 8; sh++) begin
                w      = $urandom;
                w[2:0] = sh[2:0];
                bus_cycle(mem_wr, sec_addr(1'b0), w);
                bus_cycle(mem_rd, sec_addr(1'($urandom)), 8'h00);
            end
        end
        idle_cycle();

        // Cabinet ports 1 to 3
        for (int i = 0; i < n_cab; i++) begin
            bus_cycle(io_rd, port_addr(2'(1 + i % 3)), 8'h00);
        end
        idle_cycle();

        // Sound chip registers
        for (int i = 0; i < n_psg; i++) begin
            bus_cycle(io_wr, port_addr({i[0], 1'b1}), 8'($urandom));
            bus_cycle(io_wr, port_addr({i[1], 1'b0}), 8'($urandom));
            bus_cycle(io_rd, port_addr(2'd0), 8'h00);
        end
        // Port A drives flip and the DIP bank 2 mux
        for (int sel = 0; sel < 8; sel++) begin
            w      = $urandom;
            w[3:1] = sel[2:0];
            bus_cycle(io_wr, port_addr(2'd3), 8'd14);
            bus_cycle(io_wr, port_addr(2'd2), w);
            idle_cycle();
            check_value("flip_n", flip_n, !w[0]);
            bus_cycle(io_wr, port_addr(2'd1), 8'd15);
            bus_cycle(io_rd, port_addr(2'd0), 8'h00);
            bus_cycle(io_rd, port_addr(2'd0), 8'h00);
        end
        idle_cycle();

        repeat (3) @(negedge clk);
        @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Run ended with %0d read responses never seen", exp_q.size());
            $display("** FAIL **");
            $fatal(1, "Missing responses");
        end
    end

    // Watchdog
    initial begin
        #((n_cycles + 200) * 8);
        $display("Timeout: the tests did not finish within %0d cycles", n_cycles + 200);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: sim/main_board_assertions.sv
// Bus strobe protocol checks
`timescale 1ns/10ps

module main_board_assertions
    import main_bus_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input bus_req_t cpu_req,
    input bus_rsp_t cpu_rsp,
    input logic     rom_cs
);

    logic        is_read;               // Read strobe this cycle
    int unsigned fail_count = 0;        // Failed checks so far

    assign is_read = cpu_req.valid && (cpu_req.kind == mem_rd || cpu_req.kind == io_rd);

    ////////////////////////////////////////////////////////////
    // Response timing

    // Every read answers exactly one clk later
    read_gets_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        is_read |=> cpu_rsp.valid)
        else begin
            $error("Read strobe without a response one cycle later");
            fail_count++;
        end

    // Writes and idle cycles stay silent
    no_rsp_without_read: assert property (@(posedge clk) disable iff (!rst_n)
        !is_read |=> !cpu_rsp.valid)
        else begin
            $error("Response without a read one cycle earlier");
            fail_count++;
        end

    // Pipeline empty as reset releases
    rsp_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !cpu_rsp.valid)
        else begin
            $error("Response valid right after reset");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // ROM select

    // Pin 15 is A15, so the lower 32 KB is known before unscrambling
    rom_cs_on_rom_read: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs == (cpu_req.valid && cpu_req.kind == mem_rd && !cpu_req.addr[15]))
        else begin
            $error("ROM select does not match a memory read below 32 KB");
            fail_count++;
        end

endmodule

// File: hdl/main_board.sv
// Main CPU board top level
`timescale 1ns/10ps

module main_board
    import main_bus_pkg::*;
    import cabinet_pkg::*;
#(
    parameter int ram_aw = 11           // Work RAM, 2 KB
) (
    input  logic        clk,
    input  logic        rst_n,
    // CPU bus cycles
    input  bus_req_t    cpu_req,
    output bus_rsp_t    cpu_rsp,
    // Program ROM
    output logic        rom_cs,
    output logic [14:0] rom_addr,
    input  logic [7:0]  rom_data,
    // Cabinet
    input  joy_t        joy1,
    input  joy_t        joy2,
    input  panel_t      panel,
    input  dip_t        dip,
    output logic        flip_n
);

    tgt_req_t   ram_req, sec_req, cab_req, psg_req;
    logic [7:0] wdata;
    logic [7:0] ram_rdata, sec_rdata, cab_rdata, psg_rdata;

    ////////////////////////////////////////////////////////////
    // Decode

    main_decode #(.ram_aw(ram_aw)) main_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_req   (ram_req),
        .sec_req   (sec_req),
        .cab_req   (cab_req),
        .psg_req   (psg_req),
        .wdata     (wdata),
        .ram_rdata (ram_rdata),
        .sec_rdata (sec_rdata),
        .cab_rdata (cab_rdata),
        .psg_rdata (psg_rdata)
    );

    ////////////////////////////////////////////////////////////
    // Targets

    main_ram #(.ram_aw(ram_aw)) main_ram_inst (
        .clk   (clk),
        .req   (ram_req),
        .wdata (wdata),
        .rdata (ram_rdata)
    );

    security_shift security_shift_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sec_req),
        .wdata (wdata),
        .rdata (sec_rdata)
    );

    cabinet_io cabinet_io_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (cab_req),
        .joy1  (joy1),
        .joy2  (joy2),
        .panel (panel),
        .rdata (cab_rdata)
    );

    psg_ports psg_ports_inst (      // DIPs and flip via the sound chip
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (psg_req),
        .wdata  (wdata),
        .dip    (dip),
        .rdata  (psg_rdata),
        .flip_n (flip_n)
    );

endmodule

// File: psg_ports/psg_ports.sv
// Sound chip register file and I/O ports
`timescale 1ns/10ps

module psg_ports
    import main_bus_pkg::*;
    import cabinet_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  tgt_req_t   req,
    input  logic [7:0] wdata,
    input  dip_t       dip,
    output logic [7:0] rdata,
    output logic       flip_n
);

    localparam logic [3:0] reg_ioa = 4'd14;
    localparam logic [3:0] reg_iob = 4'd15;

    logic [3:0] addr_q;                 // Latched register number
    logic [7:0] regs_q [0:15];
    logic [7:0] port_a;
    logic [7:0] port_b;
    logic [2:0] dip_sel;
    logic       wr_addr, wr_reg, rd;

    assign wr_addr = req.valid && req.write && req.addr[0];
    assign wr_reg  = req.valid && req.write && !req.addr[0];
    assign rd      = req.valid && !req.write;

    ////////////////////////////////////////////////////////////
    // Address latch and registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= 4'd0;
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= 8'd0;      // Port A low, screen upright
            end
        end else begin
            if (wr_addr) begin
                addr_q <= wdata[3:0];
            end
            if (wr_reg) begin
                regs_q[addr_q] <= wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Ports A and B

    assign port_a  = regs_q[reg_ioa];
    assign flip_n  = ~port_a[0];        // Screen flip
    assign dip_sel = port_a[3:1];       // DIP bank 2 mux

    always_comb begin
        port_b      = 8'h00;
        port_b[3:0] = dip.sw1;
        port_b[7]   = dip.sw2[dip_sel];
    end

    // Port B is input only, the stored byte never reads back
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= (addr_q == reg_iob) ? port_b : regs_q[addr_q];
        end
    end

endmodule

// File: hdl/cabinet_io.sv
// Cabinet input ports
`timescale 1ns/10ps

module cabinet_io
    import main_bus_pkg::*;
    import cabinet_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  tgt_req_t   req,
    input  joy_t       joy1,
    input  joy_t       joy2,
    input  panel_t     panel,
    output logic [7:0] rdata
);

    logic [7:0] panel_byte;
    logic [7:0] p1_byte;
    logic [7:0] p2_byte;
    logic [7:0] port_mux;

    ////////////////////////////////////////////////////////////
    // Port layouts, unused bits read high

    always_comb begin
        panel_byte      = 8'hff;
        panel_byte[7]   = panel.coin;
        panel_byte[6]   = panel.service;
        panel_byte[3:2] = panel.start;  // 2P on bit 3
    end

    always_comb begin
        p1_byte    = 8'hff;
        p1_byte[0] = joy1.left;
        p1_byte[1] = joy1.right;
        p1_byte[2] = joy1.up;
        p1_byte[3] = joy1.down;
        p1_byte[4] = joy1.punch;
    end

    always_comb begin
        p2_byte    = 8'hff;
        p2_byte[0] = joy2.left;
        p2_byte[1] = joy2.right;
        p2_byte[2] = joy2.up;
        p2_byte[3] = joy2.down;
        p2_byte[4] = joy2.punch;
    end

    // Port 0 is the sound chip and never reaches here
    always_comb begin
        case (req.addr[1:0])
            2'd1:    port_mux = panel_byte;
            2'd2:    port_mux = p2_byte;
            2'd3:    port_mux = p1_byte;
            default: port_mux = 8'hff;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Sampled on the read strobe

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= 8'hff;             // Idle bus level
        end else if (req.valid && !req.write) begin
            rdata <= port_mux;
        end
    end

endmodule

// File: security/security_shift.sv
// Protection chip
`timescale 1ns/10ps

module security_shift import main_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  tgt_req_t   req,
    input  logic [7:0] wdata,
    output logic [7:0] rdata
);

    logic [7:0]  cur_q;                 // Last byte written
    logic [7:0]  prev_q;                // Byte before it
    logic [2:0]  shamt_q;               // Bit offset into the stream
    logic        wr_data, wr_shift, rd;
    logic [15:0] word;

    assign wr_data  = req.valid && req.write && req.addr[0];
    assign wr_shift = req.valid && req.write && !req.addr[0];
    assign rd       = req.valid && !req.write;

    ////////////////////////////////////////////////////////////
    // Byte stream and shift amount

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_q   <= 8'd0;
            prev_q  <= 8'd0;
            shamt_q <= 3'd0;
        end else begin
            if (wr_data) begin
                prev_q <= cur_q;        // Older byte moves down
                cur_q  <= wdata;
            end
            if (wr_shift) begin
                shamt_q <= wdata[2:0];  // Upper bits ignored
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side

    // Current byte on top, previous below
    assign word = {cur_q, prev_q} << shamt_q;

    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= word[15:8];        // Next byte of the stream
        end
    end

endmodule

// File: hdl/main_ram.sv
// Main CPU work RAM
`timescale 1ns/10ps

module main_ram import main_bus_pkg::*; #(
    parameter int ram_aw = 11           // 2 KB by default
) (
    input  logic       clk,
    input  tgt_req_t   req,
    input  logic [7:0] wdata,
    output logic [7:0] rdata
);

    localparam int depth = 2 ** ram_aw;

    logic [7:0]        mem [0:depth-1];
    logic [ram_aw-1:0] addr;

    // Window is mirrored above ram_aw by the decoder
    assign addr = req.addr[ram_aw-1:0];

    ////////////////////////////////////////////////////////////
    // Single port, read before write

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rdata <= mem[addr];         // Old contents on every strobe
            if (req.write) begin
                mem[addr] <= wdata;
            end
        end
    end

endmodule

// File: hdl/main_decode.sv
// Main CPU address decoder
`timescale 1ns/10ps

module main_decode import main_bus_pkg::*; #(
    parameter int ram_aw = 11           // Work RAM address bits
) (
    input  logic        clk,
    input  logic        rst_n,
    input  bus_req_t    cpu_req,
    output bus_rsp_t    cpu_rsp,
    output logic        rom_cs,
    output logic [14:0] rom_addr,
    input  logic [7:0]  rom_data,       // Valid the cycle after rom_cs
    output tgt_req_t    ram_req,
    output tgt_req_t    sec_req,
    output tgt_req_t    cab_req,
    output tgt_req_t    psg_req,
    output logic [7:0]  wdata,
    input  logic [7:0]  ram_rdata,
    input  logic [7:0]  sec_rdata,
    input  logic [7:0]  cab_rdata,
    input  logic [7:0]  psg_rdata
);

    logic [15:0] s;                     // CPU pins
    logic [15:0] a;                     // Board address
    logic        is_io, is_wr, is_rd;
    logic        psg_sel, cab_sel;
    region_e     rgn;

    logic        rd_valid_q;            // Read in flight at a target
    region_e     rd_rgn_q;
    logic        rd_psg_q;              // Port read went to the sound chip

    assign s = cpu_req.addr;

    ////////////////////////////////////////////////////////////
    // Address unscrambling
    assign a[2:0]   = ~s[2:0];
    assign a[3]     = ~s[4];
    assign a[4]     = ~s[5];
    assign a[5]     = ~s[9];
    assign a[6]     = s[3];
    assign a[7]     = s[6];
    assign a[8]     = s[7];
    assign a[9]     = s[8];
    assign a[15:10] = s[15:10];         // Upper lines straight through

    assign is_io = (cpu_req.kind == io_rd) || (cpu_req.kind == io_wr);
    assign is_wr = (cpu_req.kind == mem_wr) || (cpu_req.kind == io_wr);
    assign is_rd = !is_wr;

    ////////////////////////////////////////////////////////////
    // Memory and port map
    always_comb begin
        rgn = rgn_none;
        if (is_io) begin
            rgn = rgn_io;
        end else if (!a[15]) begin
            rgn = rgn_rom;              // Lower 32 KB
        end else begin
            case (a[14:13])
                2'b00:   rgn = a[ram_aw] ? rgn_none : rgn_ram;
                2'b01:   rgn = rgn_video;
                2'b10:   rgn = rgn_bg;
                default: rgn = rgn_sec;
            endcase
        end
    end

    // Port 0 and all port writes belong to the sound chip
    assign psg_sel = is_io && (is_wr || (a[1:0] == 2'd0));
    assign cab_sel = is_io && is_rd && (a[1:0] != 2'd0);

    // ROM port, combinational in the request cycle
    assign rom_cs   = cpu_req.valid && (cpu_req.kind == mem_rd) && (rgn == rgn_rom);
    assign rom_addr = a[14:0];

    // Target strobes
    assign ram_req = '{valid: cpu_req.valid && (rgn == rgn_ram), write: is_wr, addr: a[10:0]};
    assign sec_req = '{valid: cpu_req.valid && (rgn == rgn_sec), write: is_wr, addr: a[10:0]};
    assign cab_req = '{valid: cpu_req.valid && cab_sel, write: 1'b0, addr: a[10:0]};
    assign psg_req = '{valid: cpu_req.valid && psg_sel, write: is_wr, addr: a[10:0]};
    assign wdata   = cpu_req.wdata;

    ////////////////////////////////////////////////////////////
    // Read return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            rd_rgn_q   <= rgn_none;
            rd_psg_q   <= 1'b0;
        end else begin
            rd_valid_q <= cpu_req.valid && is_rd;   // Writes never answer
            rd_rgn_q   <= rgn;
            rd_psg_q   <= psg_sel;
        end
    end

    always_comb begin
        cpu_rsp.valid = rd_valid_q;
        case (rd_rgn_q)
            rgn_rom: cpu_rsp.rdata = rom_data;
            rgn_ram: cpu_rsp.rdata = ram_rdata;
            rgn_sec: cpu_rsp.rdata = sec_rdata;
            rgn_io:  cpu_rsp.rdata = rd_psg_q ? psg_rdata : cab_rdata;
            default: cpu_rsp.rdata = 8'hff;   // Video, background, hole
        endcase
    end

endmodule

// File: common/cabinet_pkg.sv
// Cabinet control types
package cabinet_pkg;

    ////////////////////////////////////////////////////////////
    // Player controls

    // One joystick plus its punch button
    typedef struct packed {
        logic punch;
        logic down;
        logic up;
        logic right;
        logic left;
    } joy_t;

    // Coin door and start buttons
    typedef struct packed {
        logic       coin;
        logic       service;
        logic [1:0] start;    // [0] is 1P, [1] is 2P
    } panel_t;

    ////////////////////////////////////////////////////////////
    // DIP switches

    // Bank 1 is read directly on port B
    // Bank 2 goes through the port A mux, one bit at a time
    typedef struct packed {
        logic [3:0] sw1;
        logic [7:0] sw2;
    } dip_t;

endpackage

// File: common/main_bus_pkg.sv
// Main CPU bus types
package main_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Encodings

    // CPU cycle kinds, memory and port space
    typedef enum logic [1:0] {
        mem_rd = 2'd0,  // MREQ read
        mem_wr = 2'd1,  // MREQ write
        io_rd  = 2'd2,  // IORQ read
        io_wr  = 2'd3   // IORQ write
    } cycle_kind_e;

    // Where a cycle lands after decode
    typedef enum logic [2:0] {
        rgn_rom   = 3'd0,  // External program ROM
        rgn_ram   = 3'd1,  // Work RAM
        rgn_video = 3'd2,  // Text RAM, not modelled
        rgn_bg    = 3'd3,  // Background chip, not modelled
        rgn_sec   = 3'd4,  // Protection chip
        rgn_io    = 3'd5,  // Cabinet and sound-chip ports
        rgn_none  = 3'd6   // Hole above the RAM window
    } region_e;

    ////////////////////////////////////////////////////////////
    // Bus structs

    // CPU side request, one strobe per cycle
    typedef struct packed {
        logic        valid;
        cycle_kind_e kind;
        logic [15:0] addr;   // Scrambled, as on the CPU pins
        logic [7:0]  wdata;
    } bus_req_t;

    // Read response, one clk after the request
    typedef struct packed {
        logic       valid;
        logic [7:0] rdata;
    } bus_rsp_t;

    // Decoder to target strobe
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [10:0] addr;   // Unscrambled low bits
    } tgt_req_t;

endpackage
